//--- Makefile
# Verilator build and run of the VC router testbench

SIM = obj_dir/Vtb_vcr_router

compile: $(SIM)

$(SIM): files.f design/vcr_cfg.svh design/*.sv verification/*.sv
	verilator --binary --timing --assert -Wno-fatal --top-module tb_vcr_router \
		-f files.f -Mdir obj_dir

# the log decides pass or fail
run: compile
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: compile run clean

//--- design/vcr_alloc_if.sv
/* switch allocation grant of one output, driven by the global allocator
   and read by the output port and the router's pop logic */
`timescale 1ns/1ps

interface vcr_alloc_if import vcr_pkg::*; ();

  // a grant was issued this cycle
  logic gnt_v;
  // winning input, one-hot and as index
  port_oh_t gnt_in_oh;
  port_id_t gnt_in_id;
  // VC of the winning flit, kept unchanged on the way out
  vc_id_t gnt_vc;
  payload_t gnt_payload;

  // allocator side
  modport alloc (
    output gnt_v, gnt_in_oh, gnt_in_id, gnt_vc, gnt_payload
  );

  // switch traversal side
  modport out (
    input gnt_v, gnt_in_oh, gnt_in_id, gnt_vc, gnt_payload
  );

endinterface

//--- design/vcr_cfg.svh
/* router dimensions shared by the package, the RTL and the testbench;
   include wherever one of the macros is needed */
`ifndef VCR_CFG_SVH
`define VCR_CFG_SVH

// ========================================
// router size
// ========================================

// bidirectional ports, the self port is never a destination
`define VCR_NUM_PORTS 4
// virtual channels per port
`define VCR_NUM_VC 2

// ========================================
// buffers and flit
// ========================================

// flit slots per VC, also the credit count a sender starts with
`define VCR_VC_DEPTH 2
`define VCR_PAYLOAD_W 16

`endif

//--- design/vcr_input_port.sv
/* input buffer of one router port: a flit FIFO per VC, head decode
   for switch allocation and a registered credit return upstream */
`timescale 1ns/1ps
`include "vcr_cfg.svh"

module vcr_input_port import vcr_pkg::*; (
  input  logic clk_i,
  input  logic rst_n_i,

  // flits from upstream
  input  logic data_v_i,
  input  flit_t data_i,

  // pop request from switch allocation
  input  logic pop_i,
  input  vc_id_t pop_vc_i,

  // head flit of every VC
  output vc_oh_t head_v_o,
  output port_id_t [`VCR_NUM_VC-1:0] head_dst_o,
  output payload_t [`VCR_NUM_VC-1:0] head_payload_o,

  // credit back to upstream
  output logic credit_v_o,
  output vc_id_t credit_id_o
);

  typedef logic [$clog2(`VCR_VC_DEPTH)-1:0] ptr_t;

  port_id_t in_dst;
  vc_id_t in_vc;
  payload_t in_payload;

  // ========================================
  // split the incoming flit
  // ========================================

  assign in_dst = data_i[FLIT_DST_LSB +: $bits(port_id_t)];
  assign in_vc = data_i[FLIT_VC_LSB +: $bits(vc_id_t)];
  assign in_payload = data_i[`VCR_PAYLOAD_W-1:0];

  // ========================================
  // per-VC flit FIFOs
  // ========================================

  for (genvar v = 0; v < `VCR_NUM_VC; v++) begin : gen_vc_fifo
    // vc bits are implied by the FIFO, so only dst and payload are kept
    port_id_t dst_mem [`VCR_VC_DEPTH];
    payload_t payload_mem [`VCR_VC_DEPTH];
    ptr_t wr_ptr;
    ptr_t rd_ptr;
    credit_cnt_t fill;
    logic wr_en;
    logic rd_en;

    assign wr_en = data_v_i && (in_vc == vc_id_t'(v));
    assign rd_en = pop_i && (pop_vc_i == vc_id_t'(v));

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        fill <= '0;
      end else begin
        if (wr_en) begin
          wr_ptr <= (wr_ptr == ptr_t'(`VCR_VC_DEPTH-1)) ? '0 : wr_ptr + 1'b1;
        end
        if (rd_en) begin
          rd_ptr <= (rd_ptr == ptr_t'(`VCR_VC_DEPTH-1)) ? '0 : rd_ptr + 1'b1;
        end
        // simultaneous push and pop keep the level
        fill <= fill + credit_cnt_t'(wr_en) - credit_cnt_t'(rd_en);
      end
    end

    always_ff @(posedge clk_i) begin
      if (wr_en) begin
        dst_mem[wr_ptr] <= in_dst;
        payload_mem[wr_ptr] <= in_payload;
      end
    end

    // head decode, visible the cycle after the write
    assign head_v_o[v] = (fill != '0);
    assign head_dst_o[v] = dst_mem[rd_ptr];
    assign head_payload_o[v] = payload_mem[rd_ptr];

    // upstream must hold a credit for every flit it sends
    a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      wr_en |-> fill != credit_cnt_t'(`VCR_VC_DEPTH));
    // allocation only grants VCs that showed a head flit
    a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      rd_en |-> fill != '0);
  end

  // ========================================
  // credit return
  // ========================================

  // one pulse per pop, lines up with the flit leaving the switch
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      credit_v_o <= 1'b0;
    end else begin
      credit_v_o <= pop_i;
    end
  end

  always_ff @(posedge clk_i) begin
    credit_id_o <= pop_vc_i;
  end

endmodule

//--- design/vcr_output_port.sv
/* output side of one router port: switch traversal register and
   the credit counters of the downstream VC buffers */
`timescale 1ns/1ps
`include "vcr_cfg.svh"

module vcr_output_port import vcr_pkg::*; #(
  // port this output belongs to
  parameter int PORT_ID = 0
) (
  input  logic clk_i,
  input  logic rst_n_i,

  vcr_alloc_if.out gnt,

  // credits from the downstream router
  input  logic credit_v_i,
  input  vc_id_t credit_id_i,

  // VCs that can take one more flit
  output vc_oh_t credit_avail_o,

  output logic data_v_o,
  output flit_t data_o
);

  credit_cnt_t [`VCR_NUM_VC-1:0] credit_cnt;
  credit_cnt_t [`VCR_NUM_VC-1:0] credit_cnt_nxt;
  vc_oh_t credit_dec;
  vc_oh_t credit_inc;

  // ========================================
  // switch traversal
  // ========================================

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      data_v_o <= 1'b0;
    end else begin
      data_v_o <= gnt.gnt_v;
    end
  end

  // destination cleared for the next hop, VC passes through
  always_ff @(posedge clk_i) begin
    if (gnt.gnt_v) begin
      data_o <= {port_id_t'(0), gnt.gnt_vc, gnt.gnt_payload};
    end
  end

  // ========================================
  // credit counters
  // ========================================

  // a grant consumes and a credit pulse returns, both may hit one VC
  always_comb begin
    for (int v = 0; v < `VCR_NUM_VC; v++) begin
      credit_dec[v] = gnt.gnt_v && (gnt.gnt_vc == vc_id_t'(v));
      credit_inc[v] = credit_v_i && (credit_id_i == vc_id_t'(v));
      credit_cnt_nxt[v] = credit_cnt[v] - credit_cnt_t'(credit_dec[v])
                          + credit_cnt_t'(credit_inc[v]);
    end
  end

  // downstream buffers are empty after reset
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int v = 0; v < `VCR_NUM_VC; v++) begin
        credit_cnt[v] <= credit_cnt_t'(`VCR_VC_DEPTH);
      end
    end else begin
      credit_cnt <= credit_cnt_nxt;
    end
  end

  always_comb begin
    for (int v = 0; v < `VCR_NUM_VC; v++) begin
      credit_avail_o[v] = (credit_cnt[v] != '0);
    end
  end

  // ========================================
  // checks
  // ========================================

  // local allocators mask VCs without credit
  a_gnt_has_credit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    gnt.gnt_v |-> credit_cnt[gnt.gnt_vc] != '0);

  // a flit never turns back to its own port
  a_no_uturn: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    gnt.gnt_v |-> gnt.gnt_in_id != port_id_t'(PORT_ID));

  // downstream returns no more credits than flits it got
  for (genvar v = 0; v < `VCR_NUM_VC; v++) begin : gen_cnt_chk
    a_cnt_max: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      credit_cnt[v] <= credit_cnt_t'(`VCR_VC_DEPTH));
  end

endmodule

//--- design/vcr_pkg.sv
/* flit, header, port and VC types of the router;
   imported by every RTL module through its header */
`include "vcr_cfg.svh"

package vcr_pkg;

  // ========================================
  // index and one-hot types
  // ========================================

  // output port index, taken straight from the flit header
  typedef logic [$clog2(`VCR_NUM_PORTS)-1:0] port_id_t;
  typedef logic [$clog2(`VCR_NUM_VC)-1:0] vc_id_t;
  typedef logic [`VCR_NUM_PORTS-1:0] port_oh_t;
  typedef logic [`VCR_NUM_VC-1:0] vc_oh_t;

  // credits 0 .. VCR_VC_DEPTH, also used as fifo fill level
  typedef logic [$clog2(`VCR_VC_DEPTH+1)-1:0] credit_cnt_t;

  // ========================================
  // flit layout
  // ========================================

  typedef logic [`VCR_PAYLOAD_W-1:0] payload_t;

  // {dst, vc, payload}, destination in the top bits
  typedef logic [$bits(port_id_t)+$bits(vc_id_t)+`VCR_PAYLOAD_W-1:0] flit_t;

  // field offsets inside flit_t
  localparam int FLIT_VC_LSB = `VCR_PAYLOAD_W;
  localparam int FLIT_DST_LSB = FLIT_VC_LSB + $bits(vc_id_t);

endpackage

//--- design/vcr_router.sv
/* four port virtual channel router with credit flow control;
   flits leave on the VC they arrived on, two cycles when uncontended */
`timescale 1ns/1ps
`include "vcr_cfg.svh"

module vcr_router import vcr_pkg::*; (
  input  logic clk_i,
  input  logic rst_n_i,

  // upstream side of every port
  input  logic [`VCR_NUM_PORTS-1:0] data_v_i,
  input  flit_t [`VCR_NUM_PORTS-1:0] data_i,
  output logic [`VCR_NUM_PORTS-1:0] credit_v_o,
  output vc_id_t [`VCR_NUM_PORTS-1:0] credit_id_o,

  // downstream side of every port
  output logic [`VCR_NUM_PORTS-1:0] data_v_o,
  output flit_t [`VCR_NUM_PORTS-1:0] data_o,
  input  logic [`VCR_NUM_PORTS-1:0] credit_v_i,
  input  vc_id_t [`VCR_NUM_PORTS-1:0] credit_id_i
);

  vc_oh_t [`VCR_NUM_PORTS-1:0] head_v;
  port_id_t [`VCR_NUM_PORTS-1:0][`VCR_NUM_VC-1:0] head_dst;
  payload_t [`VCR_NUM_PORTS-1:0][`VCR_NUM_VC-1:0] head_payload;
  vc_oh_t [`VCR_NUM_PORTS-1:0] credit_avail;

  // local winners, indexed by input
  logic [`VCR_NUM_PORTS-1:0] req_v;
  port_id_t [`VCR_NUM_PORTS-1:0] req_dst;
  vc_id_t [`VCR_NUM_PORTS-1:0] req_vc;
  payload_t [`VCR_NUM_PORTS-1:0] req_payload;
  // requests regrouped by output
  port_oh_t [`VCR_NUM_PORTS-1:0] req_v_per_out;

  // grant copies for the pop logic
  logic [`VCR_NUM_PORTS-1:0] gnt_v;
  port_oh_t [`VCR_NUM_PORTS-1:0] gnt_in_oh;
  vc_id_t [`VCR_NUM_PORTS-1:0] gnt_vc;
  logic [`VCR_NUM_PORTS-1:0] pop;
  vc_id_t [`VCR_NUM_PORTS-1:0] pop_vc;

  vcr_alloc_if alloc_if [`VCR_NUM_PORTS] ();

  // ========================================
  // inputs and local allocation
  // ========================================

  for (genvar i = 0; i < `VCR_NUM_PORTS; i++) begin : gen_in
    vcr_input_port u_input_port (
      .clk_i, .rst_n_i,
      .data_v_i(data_v_i[i]), .data_i(data_i[i]),
      .pop_i(pop[i]), .pop_vc_i(pop_vc[i]),
      .head_v_o(head_v[i]), .head_dst_o(head_dst[i]),
      .head_payload_o(head_payload[i]),
      .credit_v_o(credit_v_o[i]), .credit_id_o(credit_id_o[i])
    );

    vcr_sa_local #(.PORT_ID(i)) u_sa_local (
      .clk_i, .rst_n_i,
      .head_v_i(head_v[i]), .head_dst_i(head_dst[i]),
      .credit_avail_i(credit_avail), .pop_i(pop[i]),
      .req_v_o(req_v[i]), .req_dst_o(req_dst[i]), .req_vc_o(req_vc[i])
    );

    // payload of the chosen head flit
    assign req_payload[i] = head_payload[i][req_vc[i]];
  end

  // ========================================
  // global allocation and outputs
  // ========================================

  for (genvar o = 0; o < `VCR_NUM_PORTS; o++) begin : gen_out
    for (genvar i = 0; i < `VCR_NUM_PORTS; i++) begin : gen_req
      if (i != o) begin : gen_other
        assign req_v_per_out[o][i] = req_v[i] && (req_dst[i] == port_id_t'(o));
      end else begin : gen_self
        // no u-turns, the own input never requests this output
        assign req_v_per_out[o][i] = 1'b0;
      end
    end

    vcr_sa_global u_sa_global (
      .clk_i, .rst_n_i,
      .req_v_i(req_v_per_out[o]), .req_vc_i(req_vc),
      .req_payload_i(req_payload), .gnt(alloc_if[o])
    );

    vcr_output_port #(.PORT_ID(o)) u_output_port (
      .clk_i, .rst_n_i, .gnt(alloc_if[o]),
      .credit_v_i(credit_v_i[o]), .credit_id_i(credit_id_i[o]),
      .credit_avail_o(credit_avail[o]),
      .data_v_o(data_v_o[o]), .data_o(data_o[o])
    );

    assign gnt_v[o] = alloc_if[o].gnt_v;
    assign gnt_in_oh[o] = alloc_if[o].gnt_in_oh;
    assign gnt_vc[o] = alloc_if[o].gnt_vc;
  end

  // an input wins at most one output, so the grants simply merge
  always_comb begin
    pop = '0;
    pop_vc = '0;
    for (int o = 0; o < `VCR_NUM_PORTS; o++) begin
      for (int i = 0; i < `VCR_NUM_PORTS; i++) begin
        if (gnt_v[o] && gnt_in_oh[o][i]) begin
          pop[i] = 1'b1;
          pop_vc[i] = gnt_vc[o];
        end
      end
    end
  end

endmodule

//--- design/vcr_sa_global.sv
/* second switch allocation stage of one output: round robin among the
   inputs whose local winner targets this output, drives the grant */
`timescale 1ns/1ps
`include "vcr_cfg.svh"

module vcr_sa_global import vcr_pkg::*; (
  input  logic clk_i,
  input  logic rst_n_i,

  // requests already sorted for this output with the self bit low
  input  port_oh_t req_v_i,
  input  vc_id_t [`VCR_NUM_PORTS-1:0] req_vc_i,
  input  payload_t [`VCR_NUM_PORTS-1:0] req_payload_i,

  vcr_alloc_if.alloc gnt
);

  // input that gets first chance this cycle
  port_id_t rr_ptr;
  logic win_v;
  port_id_t win_id;

  // ========================================
  // arbitration
  // ========================================

  always_comb begin
    int unsigned idx;
    win_v = 1'b0;
    win_id = rr_ptr;
    for (int unsigned k = 0; k < `VCR_NUM_PORTS; k++) begin
      idx = (int'(rr_ptr) + k) % `VCR_NUM_PORTS;
      if (!win_v && req_v_i[idx]) begin
        win_v = 1'b1;
        win_id = port_id_t'(idx);
      end
    end
  end

  // a grant always pops, so the pointer moves on every grant
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_ptr <= '0;
    end else if (win_v) begin
      rr_ptr <= port_id_t'((int'(win_id) + 1) % `VCR_NUM_PORTS);
    end
  end

  // ========================================
  // grant out
  // ========================================

  assign gnt.gnt_v = win_v;
  assign gnt.gnt_in_id = win_id;
  assign gnt.gnt_in_oh = win_v ? (port_oh_t'(1) << win_id) : '0;
  // VC and payload of the winning input's head flit
  assign gnt.gnt_vc = req_vc_i[win_id];
  assign gnt.gnt_payload = req_payload_i[win_id];

  // the pointer skips the last winner, so it only wins again as the lone requester
  a_rr_repeat: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    gnt.gnt_v && $past(gnt.gnt_v) && gnt.gnt_in_id == $past(gnt.gnt_in_id)
    |-> req_v_i == gnt.gnt_in_oh);

endmodule

//--- design/vcr_sa_local.sv
/* first switch allocation stage of one input: picks one head VC
   whose destination VC has a credit, round robin over the VCs */
`timescale 1ns/1ps
`include "vcr_cfg.svh"

module vcr_sa_local import vcr_pkg::*; #(
  // port this allocator belongs to
  parameter int PORT_ID = 0
) (
  input  logic clk_i,
  input  logic rst_n_i,

  input  vc_oh_t head_v_i,
  input  port_id_t [`VCR_NUM_VC-1:0] head_dst_i,
  // credit state of every output, one bit per VC
  input  vc_oh_t [`VCR_NUM_PORTS-1:0] credit_avail_i,

  // the request below was granted and popped
  input  logic pop_i,

  output logic req_v_o,
  output port_id_t req_dst_o,
  output vc_id_t req_vc_o
);

  vc_oh_t eligible;
  // VC that gets first chance this cycle
  vc_id_t rr_ptr;

  // a head flit only competes while its output VC can take it
  always_comb begin
    for (int v = 0; v < `VCR_NUM_VC; v++) begin
      eligible[v] = head_v_i[v] && credit_avail_i[head_dst_i[v]][v];
    end
  end

  // first eligible VC at or after the pointer
  always_comb begin
    int unsigned idx;
    req_v_o = 1'b0;
    req_vc_o = rr_ptr;
    for (int unsigned k = 0; k < `VCR_NUM_VC; k++) begin
      idx = (int'(rr_ptr) + k) % `VCR_NUM_VC;
      if (!req_v_o && eligible[idx]) begin
        req_v_o = 1'b1;
        req_vc_o = vc_id_t'(idx);
      end
    end
  end

  assign req_dst_o = head_dst_i[req_vc_o];

  // move past the winner only once it really left
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_ptr <= '0;
    end else if (pop_i) begin
      rr_ptr <= vc_id_t'((int'(req_vc_o) + 1) % `VCR_NUM_VC);
    end
  end

  // upstream never routes a flit back to the port it came from
  a_no_self_route: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_v_o |-> req_dst_o != port_id_t'(PORT_ID));

endmodule

//--- files.f
+incdir+design
design/vcr_pkg.sv
design/vcr_alloc_if.sv
design/vcr_input_port.sv
design/vcr_sa_local.sv
design/vcr_sa_global.sv
design/vcr_output_port.sv
design/vcr_router.sv
verification/tb_vcr_router.sv

//--- verification/tb_vcr_router.sv
/* testbench of the VC router: random traffic with upstream and downstream
   credit models, a scoreboard per output, source and VC, and a fairness phase */
`timescale 1ns/1ps
`include "vcr_cfg.svh"

module tb_vcr_router import vcr_pkg::*; ();

  localparam int NP = `VCR_NUM_PORTS;
  localparam int NV = `VCR_NUM_VC;
  localparam int DEPTH = `VCR_VC_DEPTH;
  // flits per phase whose sum sets the watchdog budget
  localparam int N_RANDOM = 300;
  localparam int N_BACKPRESSURE = 200;
  localparam int N_FAIR = 120;
  localparam int N_FLITS = 1 + N_RANDOM + N_BACKPRESSURE + N_FAIR;
  localparam int TIMEOUT_CYCLES = N_FLITS * 20;
  // output shared by the other three inputs in the fairness phase
  localparam int FAIR_OUT = 3;
  localparam int MODE_IDLE = 0;
  localparam int MODE_RANDOM = 1;
  localparam int MODE_FAIR = 2;

  logic clk_i;
  logic rst_n_i;
  logic [NP-1:0] data_v_i;
  flit_t [NP-1:0] data_i;
  logic [NP-1:0] credit_v_o;
  vc_id_t [NP-1:0] credit_id_o;
  logic [NP-1:0] data_v_o;
  flit_t [NP-1:0] data_o;
  logic [NP-1:0] credit_v_i;
  vc_id_t [NP-1:0] credit_id_i;

  logic [31:0] rng_state;
  // credits the upstream senders hold, and the router's downstream credits
  int up_credit [NP][NV];
  int ds_credit [NP][NV];
  int accepted [NP][NV];
  int returned [NP][NV];
  logic [`VCR_PAYLOAD_W-3:0] seq [NP];
  // expected payloads per output, source and VC
  payload_t sb_q [NP*NP*NV][$];
  // credits waiting to go back into the router per output
  vc_id_t ret_q [NP][$];
  int ret_wait [NP];
  int ret_max;
  int sent_cnt;
  int out_cnt;
  int n_mismatch;
  int n_error;
  string test_name;
  logic fair_on;
  port_id_t fair_hist [$];

  vcr_router uut (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .data_v_i(data_v_i), .data_i(data_i),
    .credit_v_o(credit_v_o), .credit_id_o(credit_id_o),
    .data_v_o(data_v_o), .data_o(data_o),
    .credit_v_i(credit_v_i), .credit_id_i(credit_id_i)
  );

  always #2 clk_i = ~clk_i;

  // ========================================
  // models
  // ========================================

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic int sb_index(int dst, int src, int vc);
    return (dst * NP + src) * NV + vc;
  endfunction

  // payload {source, sequence} inside a {dst, vc, payload} flit
  function automatic flit_t book_flit(int src, int dst, int vc);
    payload_t pl;
    pl = {port_id_t'(src), seq[src]};
    seq[src] = seq[src] + 1'b1;
    up_credit[src][vc]--;
    accepted[src][vc]++;
    sent_cnt++;
    sb_q[sb_index(dst, src, vc)].push_back(pl);
    return {port_id_t'(dst), vc_id_t'(vc), pl};
  endfunction

  // every input other than the shared output shows up in the last window
  function automatic logic window_fair();
    logic [NP-1:0] seen;
    seen = '0;
    for (int k = fair_hist.size() - NP; k < fair_hist.size(); k++) begin
      seen[fair_hist[k]] = 1'b1;
    end
    return seen == ~(NP'(1) << FAIR_OUT);
  endfunction

  // all flits delivered and every downstream credit back
  function automatic logic drained();
    logic done;
    done = 1'b1;
    for (int q = 0; q < NP*NP*NV; q++) begin
      if (sb_q[q].size() != 0) done = 1'b0;
    end
    for (int p = 0; p < NP; p++) begin
      if (ret_q[p].size() != 0) done = 1'b0;
      for (int v = 0; v < NV; v++) begin
        if (ds_credit[p][v] != DEPTH) done = 1'b0;
      end
    end
    return done;
  endfunction

  // ========================================
  // stimulus driven right after a rising edge
  // ========================================

  task automatic drive_cycle(int mode);
    logic [NP-1:0] v_nxt;
    flit_t [NP-1:0] d_nxt;
    logic [NP-1:0] cv_nxt;
    vc_id_t [NP-1:0] cid_nxt;
    int vc;
    int dst;
    v_nxt = '0;
    d_nxt = data_i;
    cv_nxt = '0;
    cid_nxt = credit_id_i;
    // downstream hands back at most one credit per output and cycle
    for (int o = 0; o < NP; o++) begin
      if (ret_q[o].size() > 0) begin
        if (ret_wait[o] > 0) begin
          ret_wait[o]--;
        end else begin
          cv_nxt[o] = 1'b1;
          cid_nxt[o] = ret_q[o].pop_front();
          ds_credit[o][cid_nxt[o]]++;
          ret_wait[o] = int'(next_rand() % (ret_max + 1));
        end
      end
    end
    for (int p = 0; p < NP; p++) begin
      if (mode == MODE_RANDOM && next_rand() % 4 != 0) begin
        vc = int'(next_rand() % NV);
        // never back to the source port
        dst = (p + 1 + int'(next_rand() % (NP - 1))) % NP;
        if (up_credit[p][vc] > 0) begin
          v_nxt[p] = 1'b1;
          d_nxt[p] = book_flit(p, dst, vc);
        end
      end else if (mode == MODE_FAIR && p != FAIR_OUT && up_credit[p][0] > 0) begin
        v_nxt[p] = 1'b1;
        d_nxt[p] = book_flit(p, FAIR_OUT, 0);
      end
    end
    data_v_i <= v_nxt;
    data_i <= d_nxt;
    credit_v_i <= cv_nxt;
    credit_id_i <= cid_nxt;
  endtask

  task automatic drain();
    while (!drained()) begin
      @(posedge clk_i);
      drive_cycle(MODE_IDLE);
    end
  endtask

  // ========================================
  // monitor sampling at the falling edge where outputs are stable
  // ========================================

  task automatic take_credit(int p);
    returned[p][credit_id_o[p]]++;
    up_credit[p][credit_id_o[p]]++;
    assert (up_credit[p][credit_id_o[p]] <= DEPTH) else begin
      n_error++;
      $display("error %s: input %0d returned a credit on vc %0d with no flit held",
               test_name, p, credit_id_o[p]);
    end
  endtask

  task automatic check_output(int o);
    port_id_t got_dst;
    vc_id_t got_vc;
    payload_t got_pl;
    payload_t exp_pl;
    int src;
    int idx;
    {got_dst, got_vc, got_pl} = data_o[o];
    src = int'(got_pl[`VCR_PAYLOAD_W-1 -: $bits(port_id_t)]);
    idx = sb_index(o, src, got_vc);
    out_cnt++;
    assert (got_dst == '0) else begin
      n_mismatch++;
      $display("mismatch %s: output %0d dst field expected 0 actual %0h",
               test_name, o, got_dst);
    end
    assert (ds_credit[o][got_vc] > 0) else begin
      n_error++;
      $display("error %s: output %0d sent on vc %0d without a downstream credit",
               test_name, o, got_vc);
    end
    ds_credit[o][got_vc]--;
    ret_q[o].push_back(got_vc);
    assert (sb_q[idx].size() > 0) else begin
      n_error++;
      $display("error %s: output %0d sent payload %0h on vc %0d that no input sent",
               test_name, o, got_pl, got_vc);
    end
    if (sb_q[idx].size() > 0) begin
      exp_pl = sb_q[idx].pop_front();
      assert (got_pl == exp_pl) else begin
        n_mismatch++;
        $display("mismatch %s: output %0d vc %0d input %0d expected %0h actual %0h",
                 test_name, o, got_vc, src, exp_pl, got_pl);
      end
    end
    if (fair_on && o == FAIR_OUT) begin
      fair_hist.push_back(port_id_t'(src));
      if (fair_hist.size() >= NP) begin
        assert (window_fair()) else begin
          n_error++;
          $display("error %s: an input got no grant within %0d grants at output %0d",
                   test_name, NP, o);
        end
      end
    end
  endtask

  always @(negedge clk_i) begin
    if (rst_n_i) begin
      for (int p = 0; p < NP; p++) begin
        if (credit_v_o[p]) take_credit(p);
        if (data_v_o[p]) check_output(p);
      end
    end
  end

  task automatic report_counts();
    $display("summary: %0d flits sent, %0d received, %0d mismatches, %0d other errors",
             sent_cnt, out_cnt, n_mismatch, n_error);
  endtask

  // ========================================
  // test sequence
  // ========================================

  initial begin
    flit_t one_flit;
    flit_t exp_flit;
    int latency;
    logic seen;
    int target;
    clk_i = 1'b0;
    rst_n_i = 1'b0;
    data_v_i = '0;
    data_i = '0;
    credit_v_i = '0;
    credit_id_i = '0;
    rng_state = 32'd30;
    ret_max = 5;
    sent_cnt = 0;
    out_cnt = 0;
    n_mismatch = 0;
    n_error = 0;
    fair_on = 1'b0;
    for (int p = 0; p < NP; p++) begin
      seq[p] = '0;
      ret_wait[p] = 0;
      for (int v = 0; v < NV; v++) begin
        up_credit[p][v] = DEPTH;
        ds_credit[p][v] = DEPTH;
        accepted[p][v] = 0;
        returned[p][v] = 0;
      end
    end

    test_name = "reset";
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    assert (data_v_o == '0 && credit_v_o == '0) else begin
      n_mismatch++;
      $display("mismatch %s: data_v_o,credit_v_o expected 00 actual %h%h",
               test_name, data_v_o, credit_v_o);
    end

    // one flit from input 0 to output 2 on vc 1 of an idle router
    test_name = "directed";
    @(posedge clk_i);
    one_flit = book_flit(0, 2, 1);
    data_v_i <= NP'(1);
    data_i[0] <= one_flit;
    exp_flit = {port_id_t'(0), vc_id_t'(1), one_flit[`VCR_PAYLOAD_W-1:0]};
    latency = 0;
    seen = 1'b0;
    while (!seen && latency < 10) begin
      @(posedge clk_i);
      drive_cycle(MODE_IDLE);
      latency++;
      @(negedge clk_i);
      seen = data_v_o[2];
    end
    assert (seen) else begin
      n_error++;
      $display("error %s: flit never reached output 2 within 10 cycles", test_name);
    end
    assert (latency == 2) else begin
      n_mismatch++;
      $display("mismatch %s: latency expected 2 actual %0d", test_name, latency);
    end
    assert (data_o[2] == exp_flit) else begin
      n_mismatch++;
      $display("mismatch %s: flit expected %h actual %h", test_name, exp_flit, data_o[2]);
    end
    assert (credit_v_o[0] && credit_id_o[0] == vc_id_t'(1)) else begin
      n_mismatch++;
      $display("mismatch %s: credit valid,id expected 1,1 actual %b,%0d",
               test_name, credit_v_o[0], credit_id_o[0]);
    end
    drain();

    test_name = "random";
    target = sent_cnt + N_RANDOM;
    while (sent_cnt < target) begin
      @(posedge clk_i);
      drive_cycle(MODE_RANDOM);
    end
    drain();

    // slow downstream credits hold flits back in the input FIFOs
    test_name = "backpressure";
    ret_max = 12;
    target = sent_cnt + N_BACKPRESSURE;
    while (sent_cnt < target) begin
      @(posedge clk_i);
      drive_cycle(MODE_RANDOM);
    end
    drain();

    test_name = "fairness";
    ret_max = 0;
    fair_on = 1'b1;
    target = sent_cnt + N_FAIR;
    while (sent_cnt < target) begin
      @(posedge clk_i);
      drive_cycle(MODE_FAIR);
    end
    fair_on = 1'b0;
    drain();
    assert (fair_hist.size() > NP) else begin
      n_error++;
      $display("error %s: too few grants at output %0d to judge", test_name, FAIR_OUT);
    end

    // every accepted flit gave its credit back
    test_name = "credits";
    for (int p = 0; p < NP; p++) begin
      for (int v = 0; v < NV; v++) begin
        assert (returned[p][v] == accepted[p][v]) else begin
          n_mismatch++;
          $display("mismatch %s: input %0d vc %0d expected %0d actual %0d",
                   test_name, p, v, accepted[p][v], returned[p][v]);
        end
      end
    end

    report_counts();
    if (n_mismatch == 0 && n_error == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk_i);
    $display("error %s: timeout after %0d cycles, traffic did not drain",
             test_name, TIMEOUT_CYCLES);
    report_counts();
    $display("TEST FAILED");
    $finish;
  end

endmodule
